// ==== src/cfu_pkg.sv ====
// Matrix engine CFU definitions
package cfu_pkg;

  // Command channel widths
  localparam int FUNC_ID_W = 10;
  localparam int FUNCT7_W  = 7;
  localparam int XLEN      = 32;

  // Operand buffers, 256 entries each
  localparam int BUF_ADDR_W = 8;
  localparam int A_DATA_W   = 8;
  localparam int B_DATA_W   = 32;

  // Systolic row geometry
  localparam int N_COLS = 4;
  localparam int ACC_W  = 32;

  // Dot-product length, 1 to 256
  localparam int K_W = 9;

  // Sequencer counter needs headroom past K for the drain cycles
  localparam int SEQ_CNT_W = K_W + 1;

  // Cycles after the last issued address until the row is latched
  // (read latency plus column skew plus accumulator register)
  localparam int ROW_DRAIN = N_COLS + 1;

  // funct7 codes
  localparam logic [FUNCT7_W-1:0] FN_WRITE_A = 7'd1;
  localparam logic [FUNCT7_W-1:0] FN_WRITE_B = 7'd2;
  localparam logic [FUNCT7_W-1:0] FN_COMPUTE = 7'd3;
  localparam logic [FUNCT7_W-1:0] FN_READ    = 7'd4;

  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

  typedef logic [K_W-1:0] k_len_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  typedef logic [$clog2(N_COLS)-1:0] lane_sel_t;

  // Result row, written whole and read back one lane at a time
  // Lane 0 occupies the most significant bits
  typedef union packed {
    logic [N_COLS*ACC_W-1:0] flat;
    acc_t [0:N_COLS-1]       lane;
  } result_row_u;

endpackage

// ==== src/operand_buffer.sv ====
// Operand buffer memory
`timescale 1ns/100ps

module operand_buffer #(
  parameter int DATA_W = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_en,
  input  cfu_pkg::buf_addr_t addr,
  input  logic [DATA_W-1:0]  wdata,
  output logic [DATA_W-1:0]  rdata
);
  import cfu_pkg::*;

  localparam int DEPTH = 2 ** BUF_ADDR_W;

  logic [DATA_W-1:0] mem [0:DEPTH-1];

  // Storage array, no reset
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= wdata;
    end
  end

  // Registered read, old data on a same-address write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

// ==== src/mac_pe.sv ====
// Signed multiply-accumulate cell
`timescale 1ns/100ps

module mac_pe (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clear,
  input  logic [cfu_pkg::A_DATA_W-1:0] west_in,
  input  logic [cfu_pkg::A_DATA_W-1:0] north_in,
  output logic [cfu_pkg::A_DATA_W-1:0] east_out,
  output cfu_pkg::acc_t                acc
);
  import cfu_pkg::*;

  logic signed [2*A_DATA_W-1:0] prod;

  assign prod = $signed(west_in) * $signed(north_in);

  // Accumulator wraps modulo 2^32
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;
    end else begin
      acc <= acc + acc_t'(prod);
    end
  end

  // Pass A operand on to the next column
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      east_out <= '0;
    end else begin
      east_out <= west_in;
    end
  end

endmodule

// ==== src/systolic_row.sv ====
// Systolic row with compute sequencer
`timescale 1ns/100ps

module systolic_row (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  cfu_pkg::k_len_t              k_len,
  input  logic [cfu_pkg::A_DATA_W-1:0] a_rdata,
  input  logic [cfu_pkg::B_DATA_W-1:0] b_rdata,
  output logic                         busy,
  output cfu_pkg::buf_addr_t           a_addr,
  output cfu_pkg::buf_addr_t           b_addr,
  output cfu_pkg::result_row_u         result_row
);
  import cfu_pkg::*;

  logic [SEQ_CNT_W-1:0] cnt;
  k_len_t               k_q;
  logic                 issue;
  logic                 rd_valid;
  logic                 latch;

  // West chain, entry N_COLS is the spill out of the last column
  logic [A_DATA_W-1:0] west  [0:N_COLS];
  logic [A_DATA_W-1:0] north [0:N_COLS-1];
  acc_t                acc   [0:N_COLS-1];

  // Sequencer
  // cnt is 1 in the cycle after start and counts up to K + ROW_DRAIN
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
      k_q  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      cnt  <= SEQ_CNT_W'(1);
      k_q  <= k_len;
    end else if (busy) begin
      if (latch) begin
        busy <= 1'b0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign issue = busy && (cnt <= k_q);
  assign latch = busy && (cnt == k_q + ROW_DRAIN);

  // Addresses 0 to K-1, wraps cleanly at K = 256
  assign a_addr = buf_addr_t'(cnt - 1'b1);
  assign b_addr = buf_addr_t'(cnt - 1'b1);

  // Read data arrives one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= issue;
    end
  end

  // Outside the read window the array sees zeros
  assign west[0] = rd_valid ? a_rdata : '0;

  // B byte 3-j feeds column j, delayed by j cycles
  for (genvar j = 0; j < N_COLS; j++) begin : g_skew
    logic [A_DATA_W-1:0] b_byte;

    assign b_byte = rd_valid ? b_rdata[A_DATA_W*(N_COLS-1-j) +: A_DATA_W] : '0;

    if (j == 0) begin : g_direct
      assign north[j] = b_byte;
    end else begin : g_delay
      logic [A_DATA_W-1:0] dly [1:j];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int d = 1; d <= j; d++) begin
            dly[d] <= '0;
          end
        end else begin
          dly[1] <= b_byte;
          for (int d = 2; d <= j; d++) begin
            dly[d] <= dly[d-1];
          end
        end
      end

      assign north[j] = dly[j];
    end
  end

  for (genvar j = 0; j < N_COLS; j++) begin : u_pe
    mac_pe u_mac (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (start),
      .west_in  (west[j]),
      .north_in (north[j]),
      .east_out (west[j+1]),
      .acc      (acc[j])
    );
  end

  // Result row holds until the next compute finishes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_row.flat <= '0;
    end else if (latch) begin
      for (int j = 0; j < N_COLS; j++) begin
        result_row.lane[j] <= acc[j];
      end
    end
  end

endmodule

// ==== src/cfu_cmd_decoder.sv ====
// CFU command decoder
`timescale 1ns/100ps

module cfu_cmd_decoder (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cmd_valid,
  input  logic [cfu_pkg::FUNC_ID_W-1:0] cmd_function_id,
  input  logic [cfu_pkg::XLEN-1:0]      cmd_input_0,
  input  logic [cfu_pkg::XLEN-1:0]      cmd_input_1,
  input  logic                          rsp_ready,
  input  logic                          busy,
  input  cfu_pkg::buf_addr_t            row_a_addr,
  input  cfu_pkg::buf_addr_t            row_b_addr,
  input  cfu_pkg::result_row_u          result_row,
  output logic                          cmd_ready,
  output logic                          rsp_valid,
  output cfu_pkg::acc_t                 rsp_output_0,
  output logic                          a_wr_en,
  output cfu_pkg::buf_addr_t            a_addr,
  output logic [cfu_pkg::A_DATA_W-1:0]  a_wdata,
  output logic                          b_wr_en,
  output cfu_pkg::buf_addr_t            b_addr,
  output logic [cfu_pkg::B_DATA_W-1:0]  b_wdata,
  output logic                          start,
  output cfu_pkg::k_len_t               k_len
);
  import cfu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    START,
    RUN,
    FINISH
  } state_t;

  state_t                state;
  state_t                next_state;
  logic [FUNCT7_W-1:0]   funct7;
  lane_sel_t             lane_sel;
  acc_t                  lane_q;

  assign funct7   = cmd_function_id[FUNC_ID_W-1:FUNC_ID_W-FUNCT7_W];
  assign lane_sel = cmd_input_1[$bits(lane_sel_t)-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Unknown funct7 leaves the FSM in IDLE
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (cmd_valid) begin
          case (funct7)
            FN_WRITE_A, FN_WRITE_B: next_state = WRITE;
            FN_COMPUTE:             next_state = START;
            FN_READ:                next_state = READ;
            default:                next_state = IDLE;
          endcase
        end
      end
      WRITE:   next_state = FINISH;
      READ:    next_state = FINISH;
      START:   next_state = RUN;
      RUN:     next_state = busy ? RUN : FINISH;
      FINISH:  next_state = rsp_ready ? IDLE : FINISH;
      default: next_state = IDLE;
    endcase
  end

  // Host keeps the command stable until cmd_ready
  assign a_wr_en = (state == WRITE) && (funct7 == FN_WRITE_A);
  assign b_wr_en = (state == WRITE) && (funct7 == FN_WRITE_B);
  assign a_wdata = cmd_input_1[XLEN-1 -: A_DATA_W];
  assign b_wdata = cmd_input_1[B_DATA_W-1:0];

  // Row owns the buffer addresses while it runs
  assign a_addr = (state == RUN) ? row_a_addr : cmd_input_0[BUF_ADDR_W-1:0];
  assign b_addr = (state == RUN) ? row_b_addr : cmd_input_0[BUF_ADDR_W-1:0];

  assign start = (state == START);
  assign k_len = cmd_input_0[K_W-1:0];

  // Lane captured once so the payload holds under back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_q <= '0;
    end else if (state == READ) begin
      lane_q <= result_row.lane[lane_sel];
    end
  end

  assign rsp_valid    = (state == FINISH);
  assign cmd_ready    = (state == FINISH);
  assign rsp_output_0 = lane_q;

endmodule

// ==== src/cfu_top.sv ====
// Matrix engine CFU top level
`timescale 1ns/100ps

module cfu_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cmd_valid,
  input  logic [cfu_pkg::FUNC_ID_W-1:0] cmd_function_id,
  input  logic [cfu_pkg::XLEN-1:0]      cmd_input_0,
  input  logic [cfu_pkg::XLEN-1:0]      cmd_input_1,
  input  logic                          rsp_ready,
  output logic                          cmd_ready,
  output logic                          rsp_valid,
  output cfu_pkg::acc_t                 rsp_output_0
);
  import cfu_pkg::*;

  // Buffer ports
  logic                a_wr_en;
  buf_addr_t           a_addr;
  logic [A_DATA_W-1:0] a_wdata;
  logic [A_DATA_W-1:0] a_rdata;
  logic                b_wr_en;
  buf_addr_t           b_addr;
  logic [B_DATA_W-1:0] b_wdata;
  logic [B_DATA_W-1:0] b_rdata;

  // Decoder to systolic row
  logic                start;
  k_len_t              k_len;
  logic                busy;
  buf_addr_t           row_a_addr;
  buf_addr_t           row_b_addr;
  result_row_u         result_row;

  cfu_cmd_decoder u_dec (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_function_id (cmd_function_id),
    .cmd_input_0     (cmd_input_0),
    .cmd_input_1     (cmd_input_1),
    .rsp_ready       (rsp_ready),
    .busy            (busy),
    .row_a_addr      (row_a_addr),
    .row_b_addr      (row_b_addr),
    .result_row      (result_row),
    .cmd_ready       (cmd_ready),
    .rsp_valid       (rsp_valid),
    .rsp_output_0    (rsp_output_0),
    .a_wr_en         (a_wr_en),
    .a_addr          (a_addr),
    .a_wdata         (a_wdata),
    .b_wr_en         (b_wr_en),
    .b_addr          (b_addr),
    .b_wdata         (b_wdata),
    .start           (start),
    .k_len           (k_len)
  );

  operand_buffer #(.DATA_W(A_DATA_W)) u_buf_a (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (a_wr_en),
    .addr  (a_addr),
    .wdata (a_wdata),
    .rdata (a_rdata)
  );

  operand_buffer #(.DATA_W(B_DATA_W)) u_buf_b (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (b_wr_en),
    .addr  (b_addr),
    .wdata (b_wdata),
    .rdata (b_rdata)
  );

  systolic_row u_row (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .k_len      (k_len),
    .a_rdata    (a_rdata),
    .b_rdata    (b_rdata),
    .busy       (busy),
    .a_addr     (row_a_addr),
    .b_addr     (row_b_addr),
    .result_row (result_row)
  );

endmodule

// ==== dv/cfu_chk.sv ====
// CFU handshake assertions
`timescale 1ns/100ps

module cfu_chk (
  input logic          clk,
  input logic          rst_n,
  input logic          cmd_ready,
  input logic          rsp_valid,
  input logic          rsp_ready,
  input cfu_pkg::acc_t rsp_output_0,
  input logic          busy
);

  int fail_cnt = 0;

  // Command and response complete in the same cycle
  a_ready_is_valid: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_ready == rsp_valid)
  else begin
    fail_cnt++;
    $error("cmd_ready and rsp_valid differ");
  end

  // Stalled response keeps its valid
  a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid)
  else begin
    fail_cnt++;
    $error("rsp_valid dropped while rsp_ready was low");
  end

  a_payload_held: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> $stable(rsp_output_0))
  else begin
    fail_cnt++;
    $error("rsp_output_0 changed while rsp_ready was low");
  end

  a_no_rsp_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(rsp_valid && busy))
  else begin
    fail_cnt++;
    $error("rsp_valid high while the systolic row is busy");
  end

endmodule

bind cfu_top cfu_chk u_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .cmd_ready    (cmd_ready),
  .rsp_valid    (rsp_valid),
  .rsp_ready    (rsp_ready),
  .rsp_output_0 (rsp_output_0),
  .busy         (busy)
);

// ==== dv/cfu_tb.sv ====
// Matrix engine CFU testbench
`timescale 1ns/100ps

module cfu_tb;
  import cfu_pkg::*;

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 16;
  localparam int    MAX_CMDS     = 64;
  localparam int    FILL_CMDS    = 2 * (2 ** BUF_ADDR_W);
  localparam int    CMD_CYCLES   = 270;
  localparam int    RSP_WAIT     = 300;
  localparam string GOLDEN_FILE  = "dv/cfu_golden.txt";

  logic                 clk;
  logic                 rst_n;
  logic                 cmd_valid;
  logic [FUNC_ID_W-1:0] cmd_function_id;
  logic [XLEN-1:0]      cmd_input_0;
  logic [XLEN-1:0]      cmd_input_1;
  logic                 rsp_ready;
  logic                 cmd_ready;
  logic                 rsp_valid;
  acc_t                 rsp_output_0;

  // Four words per command: funct7, input 0, input 1, expected
  logic [XLEN-1:0] golden [0:4*MAX_CMDS-1];
  int              n_golden;
  int              n_sent;
  int              n_rsp;
  int              n_val_err;
  int              n_other_err;
  int              wd_cmds;
  integer          seed;

  cfu_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_function_id (cmd_function_id),
    .cmd_input_0     (cmd_input_0),
    .cmd_input_1     (cmd_input_1),
    .rsp_ready       (rsp_ready),
    .cmd_ready       (cmd_ready),
    .rsp_valid       (rsp_valid),
    .rsp_output_0    (rsp_output_0)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Sends one command and holds it until the response is taken
  task automatic run_cmd(input logic [FUNCT7_W-1:0] f7, input logic [XLEN-1:0] in0,
                         input logic [XLEN-1:0] in1, output acc_t rsp, output bit ok);
    int stall;
    int waited;
    @(negedge clk);
    cmd_valid       = 1'b1;
    cmd_function_id = {f7, 3'b000};
    cmd_input_0     = in0;
    cmd_input_1     = in1;
    rsp_ready       = 1'b0;
    stall           = {$random(seed)} % 4;
    waited          = 0;
    rsp             = '0;
    ok              = 1'b0;
    n_sent++;
    while (!rsp_valid && waited < RSP_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!rsp_valid) begin
      $display("No response to command %0d (funct7 %0d) within %0d cycles",
               n_sent, f7, RSP_WAIT);
      n_other_err++;
    end else begin
      // Back-pressure for a few cycles before taking the response
      repeat (stall) @(negedge clk);
      rsp_ready = 1'b1;
      rsp       = rsp_output_0;
      ok        = 1'b1;
      n_rsp++;
      @(negedge clk);
    end
    cmd_valid = 1'b0;
    rsp_ready = 1'b0;
  endtask

  task automatic check_lane(input lane_sel_t lane, input acc_t got, input acc_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: lane %0d read %08h, expected %08h", $time, lane, got, exp);
      n_val_err++;
    end
  endtask

  // A[k] = k, B[k] = {k, 01, FF, ~k}, all read as signed bytes
  task automatic fill_buffers();
    logic [7:0] a;
    acc_t       rsp;
    bit         ok;
    for (int i = 0; i < 2 ** BUF_ADDR_W; i++) begin
      a = 8'(i);
      run_cmd(FN_WRITE_A, {24'h0, a}, {a, 24'h0}, rsp, ok);
      run_cmd(FN_WRITE_B, {24'h0, a}, {a, 8'h01, 8'hFF, ~a}, rsp, ok);
    end
  endtask

  initial begin : watchdog
    wait (wd_cmds > 0);
    #((wd_cmds * CMD_CYCLES + RESET_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    logic [FUNCT7_W-1:0] f7;
    acc_t                rsp;
    bit                  ok;
    seed            = 64990;
    n_golden        = 0;
    n_sent          = 0;
    n_rsp           = 0;
    n_val_err       = 0;
    n_other_err     = 0;
    wd_cmds         = 0;
    rst_n           = 1'b0;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_input_0     = '0;
    cmd_input_1     = '0;
    rsp_ready       = 1'b0;

    // All ones marks an unused slot
    for (int i = 0; i < 4 * MAX_CMDS; i++) begin
      golden[i] = '1;
    end
    $readmemh(GOLDEN_FILE, golden);
    while (n_golden < MAX_CMDS && golden[4*n_golden] !== '1) begin
      n_golden++;
    end
    if (n_golden == 0) begin
      $display("Golden file %s is empty or missing", GOLDEN_FILE);
      n_other_err++;
    end
    wd_cmds = n_golden + FILL_CMDS;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (rsp_valid !== 1'b0 || cmd_ready !== 1'b0) begin
      $display("Handshake outputs are not low after reset");
      n_other_err++;
    end

    fill_buffers();

    for (int idx = 0; idx < n_golden; idx++) begin
      f7 = golden[4*idx][FUNCT7_W-1:0];
      run_cmd(f7, golden[4*idx+1], golden[4*idx+2], rsp, ok);
      if (ok && f7 == FN_READ) begin
        check_lane(golden[4*idx+2][1:0], rsp, acc_t'(golden[4*idx+3]));
      end
    end

    @(negedge clk);
    if (n_rsp != n_sent) begin
      $display("Got %0d responses for %0d commands", n_rsp, n_sent);
      n_other_err++;
    end
    $display("Done: %0d commands, %0d responses, %0d wrong values, %0d other, %0d assertions",
             n_sent, n_rsp, n_val_err, n_other_err, dut0.u_chk.fail_cnt);
    if (n_val_err == 0 && n_other_err == 0 && dut0.u_chk.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== dv/cfu_golden.txt ====
// funct7 input_0 input_1 expected, hex, one command per line
// expected is compared on Read (04) only, buffers prefilled before line one
// Depth 256 over the prefill
03 00000100 00000000 00000000
04 00000000 00000003 FFEAAB00
04 00000000 00000000 00155580
04 00000000 00000002 00000080
04 00000000 00000001 FFFFFF80
// Depth 100 over the prefill
03 00000064 00000000 00000000
04 00000000 00000000 0005029E
04 00000000 00000001 00001356
04 00000000 00000002 FFFFECAA
04 00000000 00000003 FFFAEA0C
// Single product at address 0
01 FFFF0000 FD123456 00000000
02 00000000 05817FFE 00000000
03 00000001 00000000 00000000
04 00000000 00000000 FFFFFFF1
04 00000000 00000001 0000017D
04 00000000 00000002 FFFFFE83
04 00000000 00000003 00000006
// Depth 3 with new data at addresses 1 and 2
01 00000001 80000000 00000000
02 00000001 807F0100 00000000
01 00000002 7F000000 00000000
02 00000002 8080FF10 00000000
03 00000003 00000000 00000000
04 00000000 00000000 00000071
04 00000000 00000001 FFFF827D
04 00000000 00000002 FFFFFD84
04 00000000 00000003 000007F6
// Writes between reads
01 00000020 55000000 00000000
04 00000000 FFFFFFFE FFFFFD84
02 00000020 11223344 00000000
04 00000000 00000003 000007F6
04 00000000 00000000 00000071
04 00000000 00000001 FFFF827D
04 00000000 00000000 00000071

// ==== all.f ====
src/cfu_pkg.sv
src/operand_buffer.sv
src/mac_pe.sv
src/systolic_row.sv
src/cfu_cmd_decoder.sv
src/cfu_top.sv
dv/cfu_chk.sv
dv/cfu_tb.sv

// ==== Bender.yml ====
package:
  name: cfu_matrix

sources:
  - src/cfu_pkg.sv
  - src/operand_buffer.sv
  - src/mac_pe.sv
  - src/systolic_row.sv
  - src/cfu_cmd_decoder.sv
  - src/cfu_top.sv
  - target: test
    files:
      - dv/cfu_chk.sv
      - dv/cfu_tb.sv
